// ==== rtl/mips_defs.svh ====
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Datapath widths
`define MIPS_XLEN   32          // Data and address width
`define RF_REGS     32          // Architectural registers
`define RF_AW       5           // Register address bits

// Memory depths in words
`define IMEM_WORDS  64          // Program storage
`define IMEM_AW     6           // Instruction word index bits
`define DMEM_WORDS  64          // Data storage
`define DMEM_AW     6           // Data word index bits

`endif

// ==== rtl/mips_pkg.sv ====
`include "mips_defs.svh"

package mips_pkg;

    typedef logic [`MIPS_XLEN-1:0] word_t;      // One machine word
    typedef logic [`RF_AW-1:0]     reg_addr_t;  // Register number

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,                       // ALU ops, funct decides
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        F_ADD = 6'h20,
        F_SUB = 6'h22,
        F_AND = 6'h24,
        F_OR  = 6'h25,
        F_SLT = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT
    } alu_op_t;

    typedef enum logic {
        RES_ALU = 1'b0,                         // Writeback takes ALU result
        RES_MEM = 1'b1                          // Writeback takes load data
    } sel_result_t;

    //////////////////////////////////////////////////
    // Stage registers, all zero is a bubble

    typedef struct packed {
        word_t       instruction;
        word_t       pc_plus4;
    } if_id_t;

    typedef struct packed {
        word_t       rd0;                       // rs value
        word_t       rd1;                       // rt value
        word_t       sign_imm;
        word_t       pc_plus4;
        reg_addr_t   wa;                        // Already picked rt or rd
        alu_op_t     alu_ctrl;
        logic        rf_we;
        logic        sel_alu_b;
        logic        dmem_we;
        logic        branch;
        sel_result_t sel_result;
    } id_ex_t;

    typedef struct packed {
        word_t       alu_out;
        logic        zero;
        word_t       wd;                        // Store data
        word_t       pc_branch;
        reg_addr_t   wa;
        logic        rf_we;
        sel_result_t sel_result;
        logic        dmem_we;
        logic        branch;
    } ex_mem_t;

    typedef struct packed {
        word_t       alu_out;
        word_t       dmem_rd;
        reg_addr_t   wa;
        logic        rf_we;
        sel_result_t sel_result;
    } mem_wb_t;

endpackage

// ==== rtl/mips_ifs.sv ====
// Control unit answers the decode-stage instruction in the same cycle
interface ctrl_bus (input logic clock);
    import mips_pkg::*;

    word_t       d_instruction;                 // From if_id
    alu_op_t     alu_ctrl;
    logic        rf_we;
    logic        sel_alu_b;                     // 1 picks the immediate
    sel_result_t sel_result;
    logic        sel_wa;                        // 1 picks rd, else rt
    logic        dmem_we;
    logic        branch;

    modport cu (input clock, input d_instruction,
                output alu_ctrl, rf_we, sel_alu_b, sel_result, sel_wa, dmem_we, branch);
    modport dp (output d_instruction,
                input alu_ctrl, rf_we, sel_alu_b, sel_result, sel_wa, dmem_we, branch);
endinterface

// Register dependences and branch outcome, stall and flush back
interface hazard_bus;
    import mips_pkg::*;

    reg_addr_t d_rs, d_rt;                      // Decode sources
    reg_addr_t e_wa, m_wa, w_wa;                // Older stage destinations
    logic      e_we, m_we, w_we;
    logic      m_taken;                         // Taken beq in memory stage
    logic      stall;
    logic      flush;

    modport dp (output d_rs, d_rt, e_wa, e_we, m_wa, m_we, w_wa, w_we, m_taken,
                input stall, flush);
    modport hu (input d_rs, d_rt, e_wa, e_we, m_wa, m_we, w_wa, w_we, m_taken,
                output stall, flush);
endinterface

interface dmem_bus;
    import mips_pkg::*;

    logic  we;
    word_t addr;                                // Byte address, word aligned
    word_t wd;
    word_t rd;

    modport dp  (output we, addr, wd, input rd);
    modport mem (input we, addr, wd, output rd);
endinterface

// ==== rtl/instr_mem.sv ====
`include "mips_defs.svh"

module instr_mem (
    input  logic                clock,
    input  logic                imem_we,        // Program load strobe
    input  logic [`IMEM_AW-1:0] imem_wa,        // Word index
    input  mips_pkg::word_t     imem_wd,
    input  mips_pkg::word_t     pc,
    output mips_pkg::word_t     instruction
);
    import mips_pkg::*;

    word_t mem [`IMEM_WORDS];                   // Program words

    // Loaded by the bench while the core sits in reset
    always_ff @(posedge clock) begin
        if (imem_we) begin
            mem[imem_wa] <= imem_wd;
        end
    end

    assign instruction = mem[pc[`IMEM_AW+1:2]];    // Byte PC to word index

    // Forward-only programs ending in a self jump keep fetch in range
    a_pc_in_range: assert property (
        @(posedge clock) !$isunknown(pc) |->
            (pc[1:0] == 2'b00) && (pc < (`IMEM_WORDS * 4))
    ) else $error("PC %h left instruction memory", pc);

endmodule

// ==== rtl/control_unit.sv ====
module control_unit (
    ctrl_bus.cu ctrl
);
    import mips_pkg::*;

    opcode_t opcode;
    funct_t  funct;

    assign opcode = opcode_t'(ctrl.d_instruction[31:26]);
    assign funct  = funct_t'(ctrl.d_instruction[5:0]);

    always_comb begin
        // Defaults form a bubble
        ctrl.alu_ctrl   = ALU_ADD;
        ctrl.rf_we      = 1'b0;
        ctrl.sel_alu_b  = 1'b0;
        ctrl.sel_result = RES_ALU;
        ctrl.sel_wa     = 1'b0;
        ctrl.dmem_we    = 1'b0;
        ctrl.branch     = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.sel_wa = 1'b1;             // Destination in rd
                ctrl.rf_we  = 1'b1;
                case (funct)
                    F_ADD:   ctrl.alu_ctrl = ALU_ADD;
                    F_SUB:   ctrl.alu_ctrl = ALU_SUB;
                    F_AND:   ctrl.alu_ctrl = ALU_AND;
                    F_OR:    ctrl.alu_ctrl = ALU_OR;
                    F_SLT:   ctrl.alu_ctrl = ALU_SLT;
                    default: ctrl.rf_we    = 1'b0;    // Also the all-zero bubble
                endcase
            end
            OP_ADDI: begin
                ctrl.rf_we     = 1'b1;
                ctrl.sel_alu_b = 1'b1;
            end
            OP_LW: begin
                ctrl.rf_we      = 1'b1;
                ctrl.sel_alu_b  = 1'b1;         // Base plus offset
                ctrl.sel_result = RES_MEM;
            end
            OP_SW: begin
                ctrl.dmem_we   = 1'b1;
                ctrl.sel_alu_b = 1'b1;
            end
            OP_BEQ: begin
                ctrl.alu_ctrl = ALU_SUB;        // Zero flag means equal
                ctrl.branch   = 1'b1;
            end
            default: begin
                // j already redirected in fetch, nothing left to do
            end
        endcase
    end

    a_one_writer: assert property (
        @(posedge ctrl.clock) !(ctrl.rf_we && ctrl.dmem_we)
    ) else $error("Decode enables register and memory write together");

endmodule

// ==== rtl/hazard_unit.sv ====
module hazard_unit (
    input logic   clock,
    input logic   rst,
    hazard_bus.hu hz
);
    import mips_pkg::*;

    logic dep_rs;                               // rs still being produced
    logic dep_rt;                               // rt still being produced

    // Pending write to the same nonzero register
    function automatic logic hit(input reg_addr_t src, input reg_addr_t wa, input logic we);
        return we && (wa == src) && (src != '0);
    endfunction

    // No forwarding, so wait until writeback has retired the value
    assign dep_rs = hit(hz.d_rs, hz.e_wa, hz.e_we) ||
                    hit(hz.d_rs, hz.m_wa, hz.m_we) ||
                    hit(hz.d_rs, hz.w_wa, hz.w_we);
    assign dep_rt = hit(hz.d_rt, hz.e_wa, hz.e_we) ||
                    hit(hz.d_rt, hz.m_wa, hz.m_we) ||
                    hit(hz.d_rt, hz.w_wa, hz.w_we);

    assign hz.flush = hz.m_taken;                           // Kill three younger stages
    assign hz.stall = (dep_rs || dep_rt) && !hz.m_taken;    // Flush wins

    //////////////////////////////////////////////////
    // Checks

    // ex_mem is a bubble right after a flush
    a_flush_single: assert property (
        @(posedge clock) disable iff (rst) hz.flush |=> !hz.flush
    ) else $error("Flush held for two cycles");

    // Stage registers hold bubbles once reset has been sampled
    a_no_stall_in_reset: assert property (
        @(posedge clock) rst |=> !hz.stall
    ) else $error("Stall raised during reset");

endmodule

// ==== rtl/regfile.sv ====
`include "mips_defs.svh"

module regfile (
    input  logic                clock,
    input  logic                we,
    input  mips_pkg::reg_addr_t wa,
    input  mips_pkg::word_t     wd,
    input  mips_pkg::reg_addr_t ra0,            // rs
    input  mips_pkg::reg_addr_t ra1,            // rt
    input  mips_pkg::reg_addr_t ra2,            // Debug
    output mips_pkg::word_t     rd0,
    output mips_pkg::word_t     rd1,
    output mips_pkg::word_t     rd2
);
    import mips_pkg::*;

    word_t regs [`RF_REGS];

    // Write at the end of writeback, r0 stays untouched
    always_ff @(posedge clock) begin
        if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    assign rd0 = (ra0 == '0) ? '0 : regs[ra0];  // r0 reads zero
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// ==== rtl/datapath.sv ====
module datapath (
    input  logic                clock,
    input  logic                rst,
    input  mips_pkg::word_t     instruction,    // From instruction memory
    output mips_pkg::word_t     pc,
    ctrl_bus.dp                 ctrl,
    hazard_bus.dp               hz,
    dmem_bus.dp                 dmem,
    output mips_pkg::reg_addr_t rf_ra0,
    output mips_pkg::reg_addr_t rf_ra1,
    input  mips_pkg::word_t     rf_rd0,
    input  mips_pkg::word_t     rf_rd1,
    output logic                rf_we,
    output mips_pkg::reg_addr_t rf_wa,
    output mips_pkg::word_t     rf_wd
);
    import mips_pkg::*;

    if_id_t  if_id;
    id_ex_t  id_ex, id_ex_d;
    ex_mem_t ex_mem, ex_mem_d;
    mem_wb_t mem_wb, mem_wb_d;

    word_t pc_plus4, pc_next, jump_addr;
    word_t sign_imm, alu_b, alu_y, pc_branch;
    logic  jump;

    //////////////////////////////////////////////////
    // Fetch

    assign pc_plus4  = pc + 32'd4;
    assign jump      = (instruction[31:26] == OP_J);           // Resolved before decode
    assign jump_addr = {pc_plus4[31:28], instruction[25:0], 2'b00};

    always_comb begin
        if (hz.flush)      pc_next = ex_mem.pc_branch;         // Taken beq first
        else if (hz.stall) pc_next = pc;                       // Refetch same word
        else if (jump)     pc_next = jump_addr;
        else               pc_next = pc_plus4;
    end

    always_ff @(posedge clock) begin
        if (rst) pc <= '0;
        else     pc <= pc_next;
    end

    always_ff @(posedge clock) begin
        if (rst || hz.flush) begin
            if_id <= '0;
        end else if (!hz.stall) begin
            if_id <= '{instruction: instruction, pc_plus4: pc_plus4};
        end
    end

    //////////////////////////////////////////////////
    // Decode

    assign ctrl.d_instruction = if_id.instruction;             // Control answers same cycle
    assign rf_ra0    = if_id.instruction[25:21];
    assign rf_ra1    = if_id.instruction[20:16];
    assign hz.d_rs   = rf_ra0;
    assign hz.d_rt   = rf_ra1;
    assign sign_imm  = {{16{if_id.instruction[15]}}, if_id.instruction[15:0]};

    assign id_ex_d = '{
        rd0:        rf_rd0,
        rd1:        rf_rd1,
        sign_imm:   sign_imm,
        pc_plus4:   if_id.pc_plus4,
        wa:         ctrl.sel_wa ? if_id.instruction[15:11] : if_id.instruction[20:16],
        alu_ctrl:   ctrl.alu_ctrl,
        rf_we:      ctrl.rf_we,
        sel_alu_b:  ctrl.sel_alu_b,
        dmem_we:    ctrl.dmem_we,
        branch:     ctrl.branch,
        sel_result: ctrl.sel_result
    };

    always_ff @(posedge clock) begin
        if (rst || hz.flush || hz.stall) id_ex <= '0;          // Bubble in
        else                             id_ex <= id_ex_d;
    end

    //////////////////////////////////////////////////
    // Execute

    assign alu_b     = id_ex.sel_alu_b ? id_ex.sign_imm : id_ex.rd1;
    assign pc_branch = id_ex.pc_plus4 + {id_ex.sign_imm[29:0], 2'b00};
    assign hz.e_wa   = id_ex.wa;
    assign hz.e_we   = id_ex.rf_we;

    always_comb begin
        case (id_ex.alu_ctrl)
            ALU_ADD: alu_y = id_ex.rd0 + alu_b;
            ALU_SUB: alu_y = id_ex.rd0 - alu_b;
            ALU_AND: alu_y = id_ex.rd0 & alu_b;
            ALU_OR:  alu_y = id_ex.rd0 | alu_b;
            ALU_SLT: alu_y = {31'd0, $signed(id_ex.rd0) < $signed(alu_b)};
            default: alu_y = '0;
        endcase
    end

    assign ex_mem_d = '{
        alu_out:    alu_y,
        zero:       (alu_y == '0),
        wd:         id_ex.rd1,                                 // Store data from rt
        pc_branch:  pc_branch,
        wa:         id_ex.wa,
        rf_we:      id_ex.rf_we,
        sel_result: id_ex.sel_result,
        dmem_we:    id_ex.dmem_we,
        branch:     id_ex.branch
    };

    always_ff @(posedge clock) begin
        if (rst || hz.flush) ex_mem <= '0;                     // beq itself retires as bubble
        else                 ex_mem <= ex_mem_d;
    end

    //////////////////////////////////////////////////
    // Memory

    assign dmem.we    = ex_mem.dmem_we;
    assign dmem.addr  = ex_mem.alu_out;
    assign dmem.wd    = ex_mem.wd;
    assign hz.m_wa    = ex_mem.wa;
    assign hz.m_we    = ex_mem.rf_we;
    assign hz.m_taken = ex_mem.branch && ex_mem.zero;          // beq resolves here

    assign mem_wb_d = '{
        alu_out:    ex_mem.alu_out,
        dmem_rd:    dmem.rd,
        wa:         ex_mem.wa,
        rf_we:      ex_mem.rf_we,
        sel_result: ex_mem.sel_result
    };

    always_ff @(posedge clock) begin
        if (rst) mem_wb <= '0;
        else     mem_wb <= mem_wb_d;
    end

    //////////////////////////////////////////////////
    // Writeback

    assign rf_we   = mem_wb.rf_we;
    assign rf_wa   = mem_wb.wa;
    assign rf_wd   = (mem_wb.sel_result == RES_MEM) ? mem_wb.dmem_rd : mem_wb.alu_out;
    assign hz.w_wa = mem_wb.wa;
    assign hz.w_we = mem_wb.rf_we;

endmodule

// ==== rtl/data_mem.sv ====
`include "mips_defs.svh"

module data_mem (
    input logic  clock,
    dmem_bus.mem dm
);
    import mips_pkg::*;

    word_t               mem [`DMEM_WORDS];
    logic [`DMEM_AW-1:0] idx;                   // Word index

    assign idx = dm.addr[`DMEM_AW+1:2];

    always_ff @(posedge clock) begin
        if (dm.we) begin
            mem[idx] <= dm.wd;
        end
    end

    assign dm.rd = mem[idx];                    // Same-cycle load data

    // Only word stores inside the array
    a_store_addr: assert property (
        @(posedge clock) dm.we |->
            (dm.addr[1:0] == 2'b00) && (dm.addr < (`DMEM_WORDS * 4))
    ) else $error("Store to bad address %h", dm.addr);

endmodule

// ==== rtl/mips_top.sv ====
`include "mips_defs.svh"

module mips_top (
    input  logic                clock,
    input  logic                rst,
    input  logic                imem_we,        // Program load port
    input  logic [`IMEM_AW-1:0] imem_wa,
    input  mips_pkg::word_t     imem_wd,
    input  mips_pkg::reg_addr_t dbg_ra,         // Register peek
    output mips_pkg::word_t     dbg_rd,
    output logic                dmem_we,        // Observed store strobe
    output mips_pkg::word_t     dmem_addr,
    output mips_pkg::word_t     dmem_wd
);
    import mips_pkg::*;

    word_t     pc, instruction;
    reg_addr_t rf_ra0, rf_ra1, rf_wa;
    word_t     rf_rd0, rf_rd1, rf_wd;
    logic      rf_we;

    ctrl_bus   i_ctrl_bus (.clock(clock));
    hazard_bus i_hz_bus ();
    dmem_bus   i_dmem_bus ();

    instr_mem i_instr_mem (
        .clock(clock), .imem_we(imem_we), .imem_wa(imem_wa), .imem_wd(imem_wd),
        .pc(pc), .instruction(instruction)
    );

    datapath i_datapath (
        .clock(clock), .rst(rst), .instruction(instruction), .pc(pc),
        .ctrl(i_ctrl_bus.dp), .hz(i_hz_bus.dp), .dmem(i_dmem_bus.dp),
        .rf_ra0(rf_ra0), .rf_ra1(rf_ra1), .rf_rd0(rf_rd0), .rf_rd1(rf_rd1),
        .rf_we(rf_we), .rf_wa(rf_wa), .rf_wd(rf_wd)
    );

    control_unit i_control_unit (.ctrl(i_ctrl_bus.cu));

    hazard_unit i_hazard_unit (.clock(clock), .rst(rst), .hz(i_hz_bus.hu));

    regfile i_regfile (
        .clock(clock), .we(rf_we), .wa(rf_wa), .wd(rf_wd),
        .ra0(rf_ra0), .ra1(rf_ra1), .ra2(dbg_ra),
        .rd0(rf_rd0), .rd1(rf_rd1), .rd2(dbg_rd)
    );

    data_mem i_data_mem (.clock(clock), .dm(i_dmem_bus.mem));

    // Store side made visible
    assign dmem_we   = i_dmem_bus.we;
    assign dmem_addr = i_dmem_bus.addr;
    assign dmem_wd   = i_dmem_bus.wd;

endmodule

// ==== bench/mips_checker.sv ====
`include "mips_defs.svh"

module mips_checker (
    input  logic                clock,
    input  logic                rst,
    input  logic                imem_we,        // Program load, mirrored into the model
    input  logic [`IMEM_AW-1:0] imem_wa,
    input  mips_pkg::word_t     imem_wd,
    input  logic                dmem_we,
    input  mips_pkg::word_t     dmem_addr,
    input  mips_pkg::word_t     dmem_wd,
    input  mips_pkg::reg_addr_t dbg_ra,
    input  mips_pkg::word_t     dbg_rd,
    input  logic                reg_check,      // Register readback phase
    input  logic                test_done,      // One cycle at the end of a test
    input  int                  test_num,
    output int                  err_count,
    output int                  tests_run,
    output int                  tests_failed
);
    import mips_pkg::*;

    localparam int STEP_LIMIT = 4 * `IMEM_WORDS;   // Forward-only code runs far less

    word_t prog     [`IMEM_WORDS];
    word_t mregs    [`RF_REGS];
    logic  mvalid   [`RF_REGS];                 // Register holds a known value
    word_t mmem     [`DMEM_WORDS];
    word_t exp_addr [$];                        // Stores still to come, in order
    word_t exp_data [$];
    int    test_errs;
    int    stores_seen;

    initial begin
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_errs    = 0;
        stores_seen  = 0;
    end

    function automatic void count_error();
        test_errs++;
        err_count++;
    endfunction

    function automatic void set_reg(input reg_addr_t r, input word_t v, input logic ok);
        if (r != '0) begin                      // r0 is hardwired
            mregs[r]  = v;
            mvalid[r] = ok;
        end
    endfunction

    //////////////////////////////////////////////////
    // Instruction-level reference model

    always @(posedge clock) begin
        if (imem_we) begin
            prog[imem_wa] <= imem_wd;
        end
    end

    task automatic run_model();
        word_t     pc, next, ins, a, b, imm, ea;
        reg_addr_t rs, rt, rd;
        logic      ok, halted;
        int        steps, i;
        for (i = 0; i < `RF_REGS; i++) begin
            mregs[i]  = '0;
            mvalid[i] = (i == 0);
        end
        exp_addr.delete();
        exp_data.delete();
        pc     = '0;
        steps  = 0;
        halted = 1'b0;
        while (!halted && steps < STEP_LIMIT) begin
            ins  = prog[pc[`IMEM_AW+1:2]];
            rs   = ins[25:21];
            rt   = ins[20:16];
            rd   = ins[15:11];
            imm  = {{16{ins[15]}}, ins[15:0]};  // Sign extended
            a    = mregs[rs];
            b    = mregs[rt];
            ok   = mvalid[rs] && mvalid[rt];
            ea   = a + imm;                     // Effective address
            next = pc + 32'd4;
            case (ins[31:26])
                OP_RTYPE: begin
                    case (ins[5:0])
                        F_ADD:   set_reg(rd, a + b, ok);
                        F_SUB:   set_reg(rd, a - b, ok);
                        F_AND:   set_reg(rd, a & b, ok);
                        F_OR:    set_reg(rd, a | b, ok);
                        F_SLT:   set_reg(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0, ok);
                        default: ;              // Unknown funct writes nothing
                    endcase
                end
                OP_ADDI: set_reg(rt, ea, mvalid[rs]);
                OP_LW:   set_reg(rt, mmem[ea[`DMEM_AW+1:2]], mvalid[rs]);
                OP_SW: begin
                    exp_addr.push_back(ea);
                    exp_data.push_back(b);
                    mmem[ea[`DMEM_AW+1:2]] = b;
                end
                OP_BEQ: begin
                    if (a == b) next = pc + 32'd4 + {imm[29:0], 2'b00};
                end
                OP_J: begin
                    next   = {next[31:28], ins[25:0], 2'b00};
                    halted = (next == pc);      // Self jump ends the program
                end
                default: ;
            endcase
            pc = next;
            steps++;
        end
        if (!halted) begin
            $display("Reference model for test %0d never reached its final jump", test_num);
            count_error();
        end
    endtask

    always @(negedge rst) begin
        run_model();                            // Program fully loaded by now
    end

    //////////////////////////////////////////////////
    // Comparison against the DUT

    always @(posedge clock) begin
        if (rst) begin
            if (dmem_we === 1'b1) begin
                $display("Store strobe raised while reset is asserted at time %0t", $time);
                count_error();
            end
        end else if (dmem_we !== 1'b0) begin
            if (dmem_we !== 1'b1) begin
                $display("Store strobe is unknown at time %0t", $time);
                count_error();
            end else if (exp_addr.size() == 0) begin
                $display("Fail %0t: store of %h to %h, no store expected",
                         $time, dmem_wd, dmem_addr);
                count_error();
            end else begin
                if (dmem_addr !== exp_addr[0] || dmem_wd !== exp_data[0]) begin
                    $display("Fail %0t: store %0d wrote %h to %h, expected %h to %h",
                             $time, stores_seen, dmem_wd, dmem_addr, exp_data[0], exp_addr[0]);
                    count_error();
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
                stores_seen++;
            end
        end
        if (reg_check && mvalid[dbg_ra] && dbg_rd !== mregs[dbg_ra]) begin
            $display("Fail %0t: r%0d reads %h, expected %h", $time, dbg_ra, dbg_rd, mregs[dbg_ra]);
            count_error();
        end
        if (test_done) begin
            if (exp_addr.size() != 0) begin
                $display("Test %0d ended with %0d expected stores never seen",
                         test_num, exp_addr.size());
                count_error();
            end
            tests_run++;
            if (test_errs != 0) tests_failed++;
            $display("Test %0d: %0d stores, %0d errors, %s", test_num, stores_seen, test_errs,
                     (test_errs == 0) ? "passed" : "failed");
            test_errs   = 0;
            stores_seen = 0;
        end
    end

endmodule

// ==== bench/mips_tb.sv ====
`include "mips_defs.svh"

module mips_tb;
    import mips_pkg::*;

    localparam int NTESTS = 10;                 // Five program kinds, twice each
    localparam int PERIOD = 100;

    logic                clock;
    logic                rst;
    logic                imem_we;
    logic [`IMEM_AW-1:0] imem_wa;
    word_t               imem_wd;
    reg_addr_t           dbg_ra;
    word_t               dbg_rd;
    logic                dmem_we;
    word_t               dmem_addr;
    word_t               dmem_wd;
    logic                reg_check;
    logic                test_done;
    int                  test_num;
    int                  err_count, tests_run, tests_failed;

    integer seed = 32'h7a17;
    word_t  progs    [NTESTS][`IMEM_WORDS];
    int     prog_len [NTESTS];
    int     budget;                             // Cycles for the whole run
    logic   budget_ready;

    mips_top i_mips_top (
        .clock(clock), .rst(rst), .imem_we(imem_we), .imem_wa(imem_wa), .imem_wd(imem_wd),
        .dbg_ra(dbg_ra), .dbg_rd(dbg_rd),
        .dmem_we(dmem_we), .dmem_addr(dmem_addr), .dmem_wd(dmem_wd)
    );

    mips_checker i_mips_checker (
        .clock(clock), .rst(rst), .imem_we(imem_we), .imem_wa(imem_wa), .imem_wd(imem_wd),
        .dmem_we(dmem_we), .dmem_addr(dmem_addr), .dmem_wd(dmem_wd),
        .dbg_ra(dbg_ra), .dbg_rd(dbg_rd), .reg_check(reg_check), .test_done(test_done),
        .test_num(test_num), .err_count(err_count), .tests_run(tests_run),
        .tests_failed(tests_failed)
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    //////////////////////////////////////////////////
    // Program generation

    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic word_t enc_r(input funct_t f, input reg_addr_t rd, input reg_addr_t rs,
                                    input reg_addr_t rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, f};
    endfunction

    function automatic word_t enc_i(input opcode_t op, input reg_addr_t rt, input reg_addr_t rs,
                                    input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_j(input int target);
        return {OP_J, 26'(target)};             // Word index of the target
    endfunction

    // Kinds: 0 ALU only, 1 loads and stores, 2 dependence chain, 3 branches, 4 mixed
    task automatic gen_program(input int t);
        int        kind, n, last, cls, off, k;
        reg_addr_t rd, rs, rt, rb, prev;
        funct_t    fl [5];
        word_t     w;
        fl   = '{F_ADD, F_SUB, F_AND, F_OR, F_SLT};
        kind = t % 5;
        n    = 0;
        for (k = 1; k < 8; k++) begin           // Registers r1..r7 get known values
            progs[t][n] = enc_i(OP_ADDI, reg_addr_t'(k), '0, 16'(pick(65536)));
            n++;
        end
        if (kind == 1 || kind >= 3) begin       // Fill words 0..7 before any load
            for (k = 0; k < 8; k++) begin
                progs[t][n] = enc_i(OP_SW, reg_addr_t'(k), '0, 16'(4 * k));
                n++;
            end
        end
        last = n + 16 + int'(pick(9));
        prev = reg_addr_t'(7);
        while (n < last) begin
            rs = reg_addr_t'(pick(8));
            rt = reg_addr_t'(pick(8));
            rd = reg_addr_t'(pick(8));          // r0 allowed, must stay zero
            case (kind)
                0: cls = (pick(4) == 0) ? 1 : 0;
                1: cls = int'(pick(4));
                2: begin
                    cls  = int'(pick(2));
                    rs   = prev;                // Reads the previous result
                    rd   = reg_addr_t'(1 + pick(7));
                    prev = rd;
                end
                3: begin
                    cls = int'(pick(6));
                    if (cls == 2) cls = 4;      // Extra beq instead of lw
                end
                default: cls = int'(pick(6));
            endcase
            off = int'(pick(cls == 4 ? 4 : 3));
            if (off > last - n - 1) off = last - n - 1;    // Never past the final jump
            rb  = (pick(2) == 0) ? rs : rt;     // Same register forces a taken beq
            case (cls)
                0:       w = enc_r(fl[pick(5)], rd, rs, rt);
                1:       w = enc_i(OP_ADDI, rd, rs, 16'(pick(65536)));
                2:       w = enc_i(OP_LW, rd, '0, 16'(4 * pick(8)));
                3:       w = enc_i(OP_SW, rt, '0, 16'(4 * pick(8)));
                4:       w = enc_i(OP_BEQ, rb, rs, 16'(off));
                default: w = enc_j(n + 1 + off);
            endcase
            progs[t][n] = w;
            n++;
        end
        progs[t][last] = enc_j(last);           // Park here
        prog_len[t]    = last + 1;
    endtask

    //////////////////////////////////////////////////
    // Test sequence

    task automatic run_test(input int t);
        logic [`IMEM_AW-1:0] load_idx;
        int                  k;
        @(negedge clock);
        rst      = 1'b1;
        test_num = t;
        load_idx = '0;
        for (k = 0; k < prog_len[t]; k++) begin
            imem_we = 1'b1;
            imem_wa = load_idx;
            imem_wd = progs[t][k];
            load_idx++;
            @(negedge clock);
        end
        imem_we = 1'b0;
        repeat (4) @(negedge clock);
        rst = 1'b0;
        repeat (6 * prog_len[t] + 20) @(negedge clock);    // Worst-case run time
        reg_check = 1'b1;
        for (k = 0; k < `RF_REGS; k++) begin
            dbg_ra = reg_addr_t'(k);
            @(negedge clock);
        end
        reg_check = 1'b0;
        test_done = 1'b1;
        @(negedge clock);
        test_done = 1'b0;
    endtask

    initial begin
        rst          = 1'b1;
        imem_we      = 1'b0;
        imem_wa      = '0;
        imem_wd      = '0;
        dbg_ra       = '0;
        reg_check    = 1'b0;
        test_done    = 1'b0;
        test_num     = 0;
        budget       = 100;                     // Margin
        budget_ready = 1'b0;
        for (int t = 0; t < NTESTS; t++) begin
            gen_program(t);
            budget += 7 * prog_len[t] + 60;     // Load, reset, run and readback
        end
        budget_ready = 1'b1;
        for (int t = 0; t < NTESTS; t++) begin
            run_test(t);
        end
        @(negedge clock);
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (budget_ready === 1'b1);
        #(budget * PERIOD);
        $display("Run timed out after %0t without finishing all tests", $time);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+rtl
rtl/mips_pkg.sv
rtl/mips_ifs.sv
rtl/instr_mem.sv
rtl/control_unit.sv
rtl/hazard_unit.sv
rtl/regfile.sv
rtl/datapath.sv
rtl/data_mem.sv
rtl/mips_top.sv
bench/mips_checker.sv
bench/mips_tb.sv

// ==== Bender.yml ====
package:
  name: mips_pipeline

sources:
  # Synthesizable core
  - include_dirs:
      - rtl
    files:
      - rtl/mips_pkg.sv
      - rtl/mips_ifs.sv
      - rtl/instr_mem.sv
      - rtl/control_unit.sv
      - rtl/hazard_unit.sv
      - rtl/regfile.sv
      - rtl/datapath.sv
      - rtl/data_mem.sv
      - rtl/mips_top.sv

  # Simulation only
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/mips_checker.sv
      - bench/mips_tb.sv
